// ==== conv1x1_layer.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/pixel_ram.sv
rtl/frame_replay_buffer.sv
rtl/kernel_bank.sv
rtl/pointwise_mac.sv
rtl/conv1x1_layer.sv
sim/conv1x1_checker.sv
sim/conv1x1_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the 1x1 convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal \
	--top-module conv1x1_layer_tb \
	-f conv1x1_layer.f \
	-o conv1x1_layer_sim \
	&& ./obj_dir/conv1x1_layer_sim > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or run failed"; exit 1; }

cat "$LOG"
grep -q "RESULT: FAIL" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "No result found in $LOG"; exit 1; }
echo "Simulation passed"

// ==== sim/conv1x1_layer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv1x1_layer_tb;

	localparam int NUM_TESTS = 5;
	localparam int FRAME     = `CONV_IMAGE_SIZE;
	localparam int NCH       = `CONV_CHANNEL_NUM_OUT;

	// Pixel pattern kinds
	localparam int PAT_RAMP     = 0;
	localparam int PAT_CONSTANT = 1;
	localparam int PAT_RANDOM   = 2;
	localparam int PAT_EXTREME  = 3;

	localparam logic [15:0] EXTREMES [4] = '{16'h7fff, 16'h8000, 16'h0001, 16'hffff};

	logic             clk;
	logic             reset;
	logic             in_valid;
	conv_pkg::pixel_t in_pixel;
	logic             coef_wr;
	logic             coef_sel;
	conv_pkg::chan_t  coef_chan;
	conv_pkg::coef_t  coef_data;
	logic             busy;
	logic             out_valid;
	conv_pkg::pixel_t out_pixel;
	conv_pkg::chan_t  out_chan;
	logic             out_last;
	int               error_count;
	int               test_count;

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	string test_name [NUM_TESTS] = '{"ramp_unit", "ramp_distinct", "random_mixed",
		"extreme_saturate", "constant_rewrite"};
	int test_pattern [NUM_TESTS] = '{PAT_RAMP, PAT_RAMP, PAT_RANDOM, PAT_EXTREME, PAT_CONSTANT};
	conv_pkg::coef_t test_weight [NUM_TESTS][NCH] = '{
		'{16'h0100, 16'h0100, 16'h0100, 16'h0100},
		'{16'h0100, 16'h0200, 16'hff80, 16'h0040},
		'{16'h0180, 16'hff00, 16'h0033, 16'h0400},
		'{16'h7fff, 16'h8000, 16'h0200, 16'hfe00},
		'{16'h0200, 16'hff00, 16'h0100, 16'h0000}};
	conv_pkg::coef_t test_bias [NUM_TESTS][NCH] = '{
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0000, 16'h0100, 16'hfe00, 16'h0080},
		'{16'h0010, 16'hfff0, 16'h1000, 16'h0000},
		'{16'h7000, 16'h9000, 16'h0000, 16'h0000},
		'{16'h0001, 16'h0002, 16'hff00, 16'h1234}};
	// Largest idle gap between input strobes
	int test_gap [NUM_TESTS] = '{0, 2, 3, 1, 0};

	conv1x1_layer dut_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_pixel  (in_pixel),
		.coef_wr   (coef_wr),
		.coef_sel  (coef_sel),
		.coef_chan (coef_chan),
		.coef_data (coef_data),
		.busy      (busy),
		.out_valid (out_valid),
		.out_pixel (out_pixel),
		.out_chan  (out_chan),
		.out_last  (out_last)
	);

	conv1x1_checker checker_i (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_pixel    (in_pixel),
		.coef_wr     (coef_wr),
		.coef_sel    (coef_sel),
		.coef_chan   (coef_chan),
		.coef_data   (coef_data),
		.busy        (busy),
		.out_valid   (out_valid),
		.out_pixel   (out_pixel),
		.out_chan    (out_chan),
		.out_last    (out_last),
		.error_count (error_count),
		.test_count  (test_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic conv_pkg::pixel_t make_pixel(input int kind, input int idx);
		conv_pkg::pixel_t pix;
		case (kind)
			PAT_RAMP:     pix = conv_pkg::pixel_t'(idx * 129);
			PAT_CONSTANT: pix = 16'sh0180;
			PAT_RANDOM:   pix = conv_pkg::pixel_t'($urandom);
			default:      pix = EXTREMES[idx % 4];
		endcase
		return pix;
	endfunction

	task automatic write_coefs(input int row);
		for (int c = 0; c < NCH; c++) begin
			@(posedge clk);
			coef_wr   <= 1'b1;
			coef_sel  <= 1'b0;
			coef_chan <= conv_pkg::chan_t'(c);
			coef_data <= test_weight[row][c];
			@(posedge clk);
			coef_sel  <= 1'b1;
			coef_data <= test_bias[row][c];
		end
		@(posedge clk);
		coef_wr <= 1'b0;
	endtask

	task automatic stream_frame(input int row);
		int gap;
		for (int i = 0; i < FRAME; i++) begin
			gap = $urandom_range(test_gap[row], 0);
			repeat (gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(posedge clk);
			in_valid <= 1'b1;
			in_pixel <= make_pixel(test_pattern[row], i);
		end
		// These land while busy is high
		repeat (3) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_pixel <= 16'h5a5a;
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_frame_out();
		do @(posedge clk); while (out_last !== 1'b1);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(73811));
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_pixel  = '0;
		coef_wr   = 1'b0;
		coef_sel  = 1'b0;
		coef_chan = '0;
		coef_data = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			$display("Starting test %0d, %s", t, test_name[t]);
			write_coefs(t);
			stream_frame(t);
			wait_frame_out();
		end
		repeat (2) @(posedge clk);
		$display("Tests finished %0d of %0d, errors %0d", test_count, NUM_TESTS, error_count);
		if (error_count == 0 && test_count == NUM_TESTS) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the slowest row
	initial begin
		int max_gap;
		int limit;
		max_gap = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (test_gap[t] > max_gap) begin
				max_gap = test_gap[t];
			end
		end
		limit = NUM_TESTS * (FRAME * (max_gap + 1) + NCH * FRAME + 100);
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/conv1x1_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv1x1_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  conv_pkg::pixel_t in_pixel,
	input  logic             coef_wr,
	input  logic             coef_sel,
	input  conv_pkg::chan_t  coef_chan,
	input  conv_pkg::coef_t  coef_data,
	input  logic             busy,
	input  logic             out_valid,
	input  conv_pkg::pixel_t out_pixel,
	input  conv_pkg::chan_t  out_chan,
	input  logic             out_last,
	output int               error_count,
	output int               test_count
);

	localparam int FRAME = `CONV_IMAGE_SIZE;
	localparam int NCH   = `CONV_CHANNEL_NUM_OUT;
	localparam int TOTAL = FRAME * NCH;
	// Cycles after the last captured strobe
	localparam int OUT_DELAY   = 4;
	localparam int BUSY_CYCLES = TOTAL + 2;

	conv_pkg::pixel_t frame_model  [FRAME];
	conv_pkg::coef_t  weight_model [NCH];
	conv_pkg::coef_t  bias_model   [NCH];

	int   cycle;
	int   cap_count;
	int   done_cycle;
	int   out_idx;
	int   errors_before;
	logic capturing;
	logic frame_ready;

	// Floor of the Q16.16 product back to Q8.8, add bias, clamp
	function automatic conv_pkg::pixel_t predict(input conv_pkg::pixel_t pix,
			input conv_pkg::coef_t w, input conv_pkg::coef_t b);
		longint value;
		value = (longint'(pix) * longint'(w)) >>> `CONV_FRAC_BITS;
		value = value + longint'(b);
		if (value > 32767) begin
			value = 32767;
		end else if (value < -32768) begin
			value = -32768;
		end
		return conv_pkg::pixel_t'(value);
	endfunction

	always @(posedge clk) begin : monitor
		logic             expect_valid;
		conv_pkg::chan_t  exp_chan;
		conv_pkg::pixel_t exp_pixel;
		logic             exp_last;
		if (reset) begin
			cycle = 0;
			cap_count = 0;
			out_idx = 0;
			capturing = 1'b1;
			frame_ready = 1'b0;
			error_count = 0;
			test_count = 0;
			errors_before = 0;
			for (int c = 0; c < NCH; c++) begin
				weight_model[c] = '0;
				bias_model[c] = '0;
			end
		end else begin
			cycle++;
			// Capture reopens once the replay has drained
			if (!capturing && cycle >= done_cycle + BUSY_CYCLES) begin
				capturing = 1'b1;
				cap_count = 0;
			end
			if (busy !== !capturing) begin
				$display("** Error: busy = %h, expected %h at cycle %0d", busy, !capturing, cycle);
				error_count++;
			end

			//////////////////////////////
			// Output stream
			//////////////////////////////

			expect_valid = frame_ready && (cycle >= done_cycle + OUT_DELAY);
			if (!expect_valid) begin
				if (out_valid !== 1'b0 || out_last !== 1'b0) begin
					$display("Timing error: output strobe at cycle %0d when none is due", cycle);
					error_count++;
				end
			end else begin
				exp_chan  = conv_pkg::chan_t'(out_idx / FRAME);
				exp_pixel = predict(frame_model[out_idx % FRAME], weight_model[exp_chan],
					bias_model[exp_chan]);
				exp_last  = (out_idx == TOTAL - 1);
				if (out_valid !== 1'b1) begin
					$display("Timing error: out_valid missing for output %0d", out_idx);
					error_count++;
				end else begin
					if (out_pixel !== exp_pixel) begin
						$display("** Error: out_pixel = %h, expected %h (output %0d)",
							out_pixel, exp_pixel, out_idx);
						error_count++;
					end
					if (out_chan !== exp_chan) begin
						$display("** Error: out_chan = %h, expected %h (output %0d)",
							out_chan, exp_chan, out_idx);
						error_count++;
					end
					if (out_last !== exp_last) begin
						$display("** Error: out_last = %h, expected %h (output %0d)",
							out_last, exp_last, out_idx);
						error_count++;
					end
				end
				out_idx++;
				if (out_idx == TOTAL) begin
					frame_ready = 1'b0;
					$display("Test %0d finished, %0d errors", test_count,
						error_count - errors_before);
					test_count++;
					errors_before = error_count;
				end
			end

			if (coef_wr) begin
				if (coef_sel) begin
					bias_model[coef_chan] = coef_data;
				end else begin
					weight_model[coef_chan] = coef_data;
				end
			end

			if (in_valid && capturing) begin
				frame_model[cap_count] = in_pixel;
				cap_count++;
				if (cap_count == FRAME) begin
					capturing = 1'b0;
					frame_ready = 1'b1;
					done_cycle = cycle;
					out_idx = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/conv1x1_layer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv1x1_layer (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  conv_pkg::pixel_t in_pixel,
	input  logic             coef_wr,
	input  logic             coef_sel,
	input  conv_pkg::chan_t  coef_chan,
	input  conv_pkg::coef_t  coef_data,
	output logic             busy,
	output logic             out_valid,
	output conv_pkg::pixel_t out_pixel,
	output conv_pkg::chan_t  out_chan,
	output logic             out_last
);

	// Replay stream into the MAC
	logic             rep_valid;
	logic             rep_last;
	conv_pkg::pixel_t rep_pixel;
	conv_pkg::chan_t  rep_chan;

	// Coefficient lookup
	conv_pkg::chan_t  rd_chan;
	conv_pkg::coef_t  rd_weight;
	conv_pkg::coef_t  rd_bias;

	frame_replay_buffer frame_replay_buffer_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_pixel  (in_pixel),
		.busy      (busy),
		.rep_valid (rep_valid),
		.rep_last  (rep_last),
		.rep_pixel (rep_pixel),
		.rep_chan  (rep_chan)
	);

	kernel_bank kernel_bank_i (
		.clk       (clk),
		.reset     (reset),
		.coef_wr   (coef_wr),
		.coef_sel  (coef_sel),
		.coef_chan (coef_chan),
		.coef_data (coef_data),
		.rd_chan   (rd_chan),
		.rd_weight (rd_weight),
		.rd_bias   (rd_bias)
	);

	pointwise_mac pointwise_mac_i (
		.clk       (clk),
		.reset     (reset),
		.rep_valid (rep_valid),
		.rep_last  (rep_last),
		.rep_pixel (rep_pixel),
		.rep_chan  (rep_chan),
		.rd_chan   (rd_chan),
		.rd_weight (rd_weight),
		.rd_bias   (rd_bias),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_pixel (out_pixel),
		.out_chan  (out_chan)
	);

endmodule

`default_nettype wire

// ==== rtl/pointwise_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module pointwise_mac (
	input  logic             clk,
	input  logic             reset,
	input  logic             rep_valid,
	input  logic             rep_last,
	input  conv_pkg::pixel_t rep_pixel,
	input  conv_pkg::chan_t  rep_chan,
	output conv_pkg::chan_t  rd_chan,
	input  conv_pkg::coef_t  rd_weight,
	input  conv_pkg::coef_t  rd_bias,
	output logic             out_valid,
	output logic             out_last,
	output conv_pkg::pixel_t out_pixel,
	output conv_pkg::chan_t  out_chan
);

	localparam int PIXEL_W = $bits(conv_pkg::pixel_t);
	localparam conv_pkg::product_t SAT_MAX = 2 ** (PIXEL_W - 1) - 1;
	localparam conv_pkg::product_t SAT_MIN = -(2 ** (PIXEL_W - 1));

	logic               s1_valid;
	logic               s1_last;
	conv_pkg::chan_t    s1_chan;
	conv_pkg::product_t s1_product;
	conv_pkg::coef_t    s1_bias;
	conv_pkg::product_t sum;

	//////////////////////////////
	// Stage 1, bank read and multiply
	//////////////////////////////

	assign rd_chan = rep_chan;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
		end else begin
			s1_valid <= rep_valid;
			s1_last  <= rep_last;
		end
	end

	always_ff @(posedge clk) begin
		s1_product <= conv_pkg::product_t'(rep_pixel) * conv_pkg::product_t'(rd_weight);
		s1_bias    <= rd_bias;
		s1_chan    <= rep_chan;
	end

	//////////////////////////////
	// Stage 2, rescale, bias and saturate
	//////////////////////////////

	// Arithmetic shift floors toward minus infinity
	assign sum = (s1_product >>> `CONV_FRAC_BITS) + conv_pkg::product_t'(s1_bias);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= s1_valid;
			out_last  <= s1_last;
		end
	end

	always_ff @(posedge clk) begin
		out_chan <= s1_chan;
		if (sum > SAT_MAX) begin
			out_pixel <= SAT_MAX[PIXEL_W-1:0];
		end else if (sum < SAT_MIN) begin
			out_pixel <= SAT_MIN[PIXEL_W-1:0];
		end else begin
			out_pixel <= sum[PIXEL_W-1:0];
		end
	end

	a_last_valid: assert property (@(posedge clk) disable iff (reset)
		out_last |-> out_valid)
		else $error("out_last without out_valid");

endmodule

`default_nettype wire

// ==== rtl/kernel_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module kernel_bank (
	input  logic            clk,
	input  logic            reset,
	input  logic            coef_wr,
	input  logic            coef_sel,
	input  conv_pkg::chan_t coef_chan,
	input  conv_pkg::coef_t coef_data,
	input  conv_pkg::chan_t rd_chan,
	output conv_pkg::coef_t rd_weight,
	output conv_pkg::coef_t rd_bias
);

	conv_pkg::coef_t weight_q [`CONV_CHANNEL_NUM_OUT];
	conv_pkg::coef_t bias_q   [`CONV_CHANNEL_NUM_OUT];

	// Host strobe writes the weight when sel is 0 and the bias when sel is 1
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CONV_CHANNEL_NUM_OUT; i++) begin
				weight_q[i] <= '0;
				bias_q[i]   <= '0;
			end
		end else if (coef_wr) begin
			if (coef_sel) begin
				bias_q[coef_chan] <= coef_data;
			end else begin
				weight_q[coef_chan] <= coef_data;
			end
		end
	end

	// Combinational read for the MAC
	assign rd_weight = weight_q[rd_chan];
	assign rd_bias   = bias_q[rd_chan];

endmodule

`default_nettype wire

// ==== rtl/frame_replay_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module frame_replay_buffer (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  conv_pkg::pixel_t in_pixel,
	output logic             busy,
	output logic             rep_valid,
	output logic             rep_last,
	output conv_pkg::pixel_t rep_pixel,
	output conv_pkg::chan_t  rep_chan
);

	localparam logic [1:0] ST_CAPTURE = 2'd0;
	localparam logic [1:0] ST_REPLAY  = 2'd1;
	localparam logic [1:0] ST_DRAIN   = 2'd2;

	localparam conv_pkg::pixel_addr_t LAST_ADDR = conv_pkg::pixel_addr_t'(`CONV_IMAGE_SIZE - 1);
	localparam conv_pkg::chan_t LAST_CHAN = conv_pkg::chan_t'(`CONV_CHANNEL_NUM_OUT - 1);

	logic [1:0]            state;
	logic                  capture;
	logic                  reading;
	conv_pkg::pixel_addr_t cap_addr;

	logic                  wr_pend;
	conv_pkg::pixel_addr_t wr_addr;
	conv_pkg::pixel_t      wr_pixel;

	logic                  ram_en;
	logic                  ram_we;
	conv_pkg::pixel_addr_t ram_addr;
	conv_pkg::pixel_t      ram_dout;

	conv_pkg::pixel_addr_t rd_addr;
	conv_pkg::chan_t       rd_chan;
	logic                  rd_end_addr;

	logic                  tag_valid;
	logic                  tag_last;
	logic                  tag_hold;
	conv_pkg::chan_t       tag_chan;

	assign busy        = (state != ST_CAPTURE);
	assign reading     = (state == ST_REPLAY);
	assign capture     = in_valid && (state == ST_CAPTURE);
	assign rd_end_addr = (rd_addr == LAST_ADDR);

	//////////////////////////////
	// Capture side
	//////////////////////////////

	// Pixel and address wait one cycle before the RAM write
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= capture;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			wr_pixel <= in_pixel;
			wr_addr  <= cap_addr;
		end
	end

	//////////////////////////////
	// Capture / replay FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_CAPTURE;
			cap_addr <= '0;
			rd_addr  <= '0;
			rd_chan  <= '0;
		end else begin
			case (state)
				ST_CAPTURE: begin
					if (capture) begin
						cap_addr <= cap_addr + 1'b1;
						if (cap_addr == LAST_ADDR) begin
							state   <= ST_REPLAY;
							rd_addr <= '0;
							rd_chan <= '0;
						end
					end
				end
				ST_REPLAY: begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_end_addr) begin
						if (rd_chan == LAST_CHAN) begin
							state <= ST_DRAIN;
						end else begin
							rd_chan <= rd_chan + 1'b1;
						end
					end
				end
				// Last pixel leaves the RAM pipeline here
				ST_DRAIN: begin
					state    <= ST_CAPTURE;
					cap_addr <= '0;
				end
				default: state <= ST_CAPTURE;
			endcase
		end
	end

	//////////////////////////////
	// RAM port and read tags
	//////////////////////////////

	// The final pixel of a frame is never written, since the port already
	// reads address 0 on that cycle. Address 255 is served from wr_pixel
	assign ram_we   = wr_pend && (wr_addr != LAST_ADDR);
	assign ram_en   = ram_we || reading;
	assign ram_addr = reading ? rd_addr : wr_addr;

	pixel_ram pixel_ram_i (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.addr (ram_addr),
		.din  (wr_pixel),
		.dout (ram_dout)
	);

	// Tags lined up with the one-cycle RAM latency
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid <= 1'b0;
			tag_last  <= 1'b0;
		end else begin
			tag_valid <= reading;
			tag_last  <= reading && rd_end_addr && (rd_chan == LAST_CHAN);
		end
	end

	always_ff @(posedge clk) begin
		tag_chan <= rd_chan;
		tag_hold <= rd_end_addr;
	end

	assign rep_valid = tag_valid;
	assign rep_last  = tag_last;
	assign rep_chan  = tag_chan;
	assign rep_pixel = tag_hold ? wr_pixel : ram_dout;

	a_no_write_busy: assert property (@(posedge clk) disable iff (reset)
		ram_we |-> !busy)
		else $error("pixel RAM written during replay");

endmodule

`default_nettype wire

// ==== rtl/pixel_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module pixel_ram (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  conv_pkg::pixel_addr_t addr,
	input  conv_pkg::pixel_t      din,
	output conv_pkg::pixel_t      dout
);

	// One frame of storage
	conv_pkg::pixel_t mem [0:`CONV_IMAGE_SIZE-1];

	// Read-first single port, registered output
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/conv_pkg.sv ====
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

	// Signed Q8.8 pixel, layer input and output
	typedef logic signed [15:0] pixel_t;

	// Signed Q8.8 weight or bias
	typedef logic signed [15:0] coef_t;

	// Full-width product of pixel and weight, Q16.16
	typedef logic signed [31:0] product_t;

	typedef logic [`CONV_ADDR_WIDTH-1:0] pixel_addr_t;

	typedef logic [`CONV_CHAN_WIDTH-1:0] chan_t;

endpackage

`default_nettype wire

// ==== rtl/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

//////////////////////////////
// Frame geometry
//////////////////////////////

// Pixels per row, square frame
`define CONV_IMAGE_WIDTH 16

`define CONV_IMAGE_SIZE (`CONV_IMAGE_WIDTH * `CONV_IMAGE_WIDTH)

// Enough bits to address one frame
`define CONV_ADDR_WIDTH 8

//////////////////////////////
// Channels and number format
//////////////////////////////

`define CONV_CHANNEL_NUM_OUT 4

`define CONV_CHAN_WIDTH 2

// Q8.8 for pixels, weights and biases
`define CONV_FRAC_BITS 8

`endif
